// ==== cpu_pkg.sv ====
// opcode values are fixed for program.hex; st and out send rs2, ld and st address by rs1
package cpu_pkg;

    // memory sizes
    localparam int rom_depth = 64;
    localparam int ram_depth = 16;
    localparam int rom_addr_width = $clog2(rom_depth);
    localparam int ram_addr_width = $clog2(ram_depth);
    localparam string rom_file = "program.hex";

    typedef logic [15:0] word_t;
    typedef logic [3:0] reg_index_t;

    typedef enum logic [3:0] {
        op_nop = 4'h0,
        op_add = 4'h1,
        op_sub = 4'h2,
        op_and = 4'h3,
        op_or  = 4'h4,
        op_li  = 4'h5,
        op_ld  = 4'h6,
        op_st  = 4'h7,
        op_in  = 4'h8,
        op_out = 4'h9,
        op_beq = 4'ha,
        op_jmp = 4'hb
    } opcode_t;

    // li and jmp use i_view, all others r_view
    // beq keeps its signed word offset in the rd field, jmp is pc relative too
    typedef union packed {
        struct packed {
            reg_index_t rs2;
            reg_index_t rs1;
            reg_index_t rd;
            opcode_t    op;
        } r_view;
        struct packed {
            logic [7:0] imm8;
            reg_index_t rd;
            opcode_t    op;
        } i_view;
    } instr_t;

    typedef enum logic [1:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or
    } alu_op_t;

endpackage

// ==== decode_stage.sv ====
// unused source fields decode as r0 so they never forward or stall; in is treated like a load
`timescale 1ns/100ps

module decode_stage import cpu_pkg::*; (
    input  logic       clock,
    input  logic       reset,
    input  instr_t     instruction,
    input  word_t      pc,
    input  logic       valid,
    input  logic       flush,
    input  logic       wb_valid,
    input  reg_index_t wb_rd,
    input  word_t      wb_data,
    output logic       stall,
    de_bus.producer    de
);

    word_t      regs [16];
    opcode_t    op;
    reg_index_t rs1;
    reg_index_t rs2;
    reg_index_t rd;
    word_t      imm;
    word_t      a;
    word_t      b;

    // field split through the union
    always_comb begin
        op  = instruction.r_view.op;
        rs1 = '0;
        rs2 = '0;
        rd  = '0;
        imm = '0;
        case (op)
            op_add, op_sub, op_and, op_or: begin
                rs1 = instruction.r_view.rs1;
                rs2 = instruction.r_view.rs2;
                rd  = instruction.r_view.rd;
            end
            op_li: begin
                rd  = instruction.i_view.rd;
                imm = {{8{instruction.i_view.imm8[7]}}, instruction.i_view.imm8};
            end
            op_ld: begin
                rs1 = instruction.r_view.rs1;
                rd  = instruction.r_view.rd;
            end
            op_st: begin
                rs1 = instruction.r_view.rs1;
                rs2 = instruction.r_view.rs2;
            end
            op_in:  rd  = instruction.r_view.rd;
            op_out: rs2 = instruction.r_view.rs2;
            op_beq: begin
                rs1 = instruction.r_view.rs1;
                rs2 = instruction.r_view.rs2;
                // offset sits in the rd field
                imm = {{12{instruction.r_view.rd[3]}}, instruction.r_view.rd};
            end
            op_jmp: imm = {{8{instruction.i_view.imm8[7]}}, instruction.i_view.imm8};
            default: ;
        endcase
    end

    // register file, r0 reads as zero, same-cycle write returns the new value
    assign a = (rs1 == '0) ? '0 : (wb_valid && wb_rd == rs1) ? wb_data : regs[rs1];
    assign b = (rs2 == '0) ? '0 : (wb_valid && wb_rd == rs2) ? wb_data : regs[rs2];

    always_ff @(posedge clock) begin
        if (wb_valid && wb_rd != '0) begin
            regs[wb_rd] <= wb_data;
        end
    end

    // result of ld or in only exists after the memory stage
    assign stall = valid && de.valid && (de.op == op_ld || de.op == op_in)
                   && de.rd != '0 && (rs1 == de.rd || rs2 == de.rd);

    always_ff @(posedge clock) begin
        if (reset) begin
            de.valid     <= 1'b0;
            de.reg_write <= 1'b0;
        end else if (flush || stall) begin
            // bubble
            de.valid     <= 1'b0;
            de.reg_write <= 1'b0;
        end else begin
            de.valid     <= valid;
            de.reg_write <= valid && rd != '0;
        end
    end

    always_ff @(posedge clock) begin
        de.pc  <= pc;
        de.op  <= op;
        de.a   <= a;
        de.b   <= b;
        de.imm <= imm;
        de.rs1 <= rs1;
        de.rs2 <= rs2;
        de.rd  <= rd;
    end

endmodule

// ==== execute_stage.sv ====
// em forwarding skips ld and in, whose data decode covers by stalling; branches resolve here
`timescale 1ns/100ps

module execute_stage import cpu_pkg::*; (
    input  logic       clock,
    input  logic       reset,
    de_bus.consumer    de,
    input  logic       wb_valid,
    input  reg_index_t wb_rd,
    input  word_t      wb_data,
    em_bus.producer    em,
    output logic       redirect,
    output word_t      target
);

    logic    em_forwardable;
    word_t   op_a;
    word_t   op_b;
    word_t   rhs;
    word_t   result;
    alu_op_t alu_op;

    assign em_forwardable = em.valid && em.reg_write && em.op != op_ld && em.op != op_in;

    // youngest producer first, r0 never matches
    assign op_a = (de.rs1 != '0 && em_forwardable && em.rd == de.rs1) ? em.alu_result :
                  (de.rs1 != '0 && wb_valid && wb_rd == de.rs1) ? wb_data : de.a;
    assign op_b = (de.rs2 != '0 && em_forwardable && em.rd == de.rs2) ? em.alu_result :
                  (de.rs2 != '0 && wb_valid && wb_rd == de.rs2) ? wb_data : de.b;

    always_comb begin
        case (de.op)
            op_sub:  alu_op = alu_sub;
            op_and:  alu_op = alu_and;
            op_or:   alu_op = alu_or;
            default: alu_op = alu_add;
        endcase
    end

    // li adds imm to r0, ld and st add a zero offset to the address
    assign rhs = (de.op == op_li || de.op == op_ld || de.op == op_st) ? de.imm : op_b;

    always_comb begin
        case (alu_op)
            alu_sub: result = op_a - rhs;
            alu_and: result = op_a & rhs;
            alu_or:  result = op_a | rhs;
            default: result = op_a + rhs;
        endcase
    end

    // taken branch flushes fetch and decode at the next edge
    assign redirect = de.valid && (de.op == op_jmp || (de.op == op_beq && op_a == op_b));
    assign target = de.pc + 16'd1 + de.imm;

    always_ff @(posedge clock) begin
        if (reset) begin
            em.valid     <= 1'b0;
            em.reg_write <= 1'b0;
        end else begin
            em.valid     <= de.valid;
            em.reg_write <= de.valid && de.reg_write;
        end
    end

    always_ff @(posedge clock) begin
        em.op         <= de.op;
        em.alu_result <= result;
        // st and out both send rs2
        em.store_data <= op_b;
        em.rd         <= de.rd;
    end

endmodule

// ==== fetch_stage.sv ====
// rom is loaded once from rom_file at start; pc wraps inside the rom, redirect beats stall
`timescale 1ns/100ps

module fetch_stage import cpu_pkg::*; (
    input  logic   clock,
    input  logic   reset,
    input  logic   stall,
    input  logic   redirect,
    input  word_t  target,
    output instr_t instruction,
    output word_t  pc,
    output logic   valid
);

    word_t fetch_pc;
    word_t rom [rom_depth];

    initial begin
        $readmemh(rom_file, rom);
    end

    // program counter and valid bit of the fetch-to-decode register
    always_ff @(posedge clock) begin
        if (reset) begin
            fetch_pc <= '0;
            valid    <= 1'b0;
        end else if (redirect) begin
            // younger instruction is dropped
            fetch_pc <= target;
            valid    <= 1'b0;
        end else if (!stall) begin
            fetch_pc <= fetch_pc + 16'd1;
            valid    <= 1'b1;
        end
    end

    // instruction and its pc, held while decode stalls
    always_ff @(posedge clock) begin
        if (!stall) begin
            instruction <= rom[fetch_pc[rom_addr_width-1:0]];
            pc          <= fetch_pc;
        end
    end

endmodule

// ==== list.f ====
cpu_pkg.sv
stage_if.sv
fetch_stage.sv
decode_stage.sv
execute_stage.sv
memory_stage.sv
load_store.sv
load_store_assertions.sv
load_store_tb.sv

// ==== load_store.sv ====
// no back-pressure on either port; strobes mark every transfer, latency depends on the program
`timescale 1ns/100ps

module load_store import cpu_pkg::*; (
    input  logic  clock,
    input  logic  reset,
    input  word_t read_in,
    output logic  read_strobe,
    output word_t write_out,
    output logic  write_strobe
);

    // fetch to decode
    instr_t     fd_instruction;
    word_t      fd_pc;
    logic       fd_valid;

    // hazard and branch control
    logic       stall;
    logic       redirect;
    word_t      target;

    // writeback, also used for forwarding
    logic       wb_valid;
    reg_index_t wb_rd;
    word_t      wb_data;

    de_bus de_if ();
    em_bus em_if ();

    fetch_stage fetch_inst (
        .clock       (clock),
        .reset       (reset),
        .stall       (stall),
        .redirect    (redirect),
        .target      (target),
        .instruction (fd_instruction),
        .pc          (fd_pc),
        .valid       (fd_valid)
    );

    decode_stage decode_inst (
        .clock       (clock),
        .reset       (reset),
        .instruction (fd_instruction),
        .pc          (fd_pc),
        .valid       (fd_valid),
        .flush       (redirect),
        .wb_valid    (wb_valid),
        .wb_rd       (wb_rd),
        .wb_data     (wb_data),
        .stall       (stall),
        .de          (de_if.producer)
    );

    execute_stage execute_inst (
        .clock    (clock),
        .reset    (reset),
        .de       (de_if.consumer),
        .wb_valid (wb_valid),
        .wb_rd    (wb_rd),
        .wb_data  (wb_data),
        .em       (em_if.producer),
        .redirect (redirect),
        .target   (target)
    );

    memory_stage memory_inst (
        .clock        (clock),
        .reset        (reset),
        .em           (em_if.consumer),
        .read_in      (read_in),
        .read_strobe  (read_strobe),
        .write_out    (write_out),
        .write_strobe (write_strobe),
        .wb_valid     (wb_valid),
        .wb_rd        (wb_rd),
        .wb_data      (wb_data)
    );

endmodule

// ==== load_store_assertions.sv ====
// checks only the port strobes and write_out of load_store, sampled on the rising clock edge
`timescale 1ns/100ps

module load_store_assertions import cpu_pkg::*; (
    input logic  clock,
    input logic  reset,
    input logic  read_strobe,
    input logic  write_strobe,
    input word_t write_out
);

    // first cycle out of reset
    strobes_low_after_reset: assert property (
        @(posedge clock) $fell(reset) |-> !read_strobe && !write_strobe
    ) else $error("a strobe is high in the first cycle after reset");

    one_strobe_at_a_time: assert property (
        @(posedge clock) disable iff (reset) !(read_strobe && write_strobe)
    ) else $error("read_strobe and write_strobe are high in the same cycle");

    // output register only loads with its strobe
    output_held_between_strobes: assert property (
        @(posedge clock) disable iff (reset) !write_strobe |-> $stable(write_out)
    ) else $error("write_out changed while write_strobe was low");

endmodule

bind load_store load_store_assertions assertions_inst (
    .clock        (clock),
    .reset        (reset),
    .read_strobe  (read_strobe),
    .write_strobe (write_strobe),
    .write_out    (write_out)
);

// ==== load_store_tb.sv ====
// needs program.hex in the working directory; outputs are checked against the in/add/sub/or rule
`timescale 1ns/100ps

module load_store_tb import cpu_pkg::*; ();

    localparam int entry_count = 8;
    localparam int timeout_cycles = 60;

    // one input pair and the outputs it should produce
    typedef struct packed {
        word_t x;
        word_t y;
        word_t sum;
        word_t diff;
        word_t or_val;
        logic  has_or;
    } entry_t;

    logic        clock;
    logic        reset;
    word_t       read_in;
    logic        read_strobe;
    word_t       write_out;
    logic        write_strobe;

    entry_t      entries [entry_count];
    logic [15:0] lfsr_state;

    load_store load_store_inst (
        .clock        (clock),
        .reset        (reset),
        .read_in      (read_in),
        .read_strobe  (read_strobe),
        .write_out    (write_out),
        .write_strobe (write_strobe)
    );

    initial begin
        clock = 1'b0;
        forever begin
            #20 clock = ~clock;
        end
    end

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] state);
        logic feedback;
        feedback = state[15] ^ state[13] ^ state[12] ^ state[10];
        return {state[14:0], feedback};
    endfunction

    task automatic random_word(output word_t value);
        value = '0;
        for (int bit_index = 0; bit_index < 16; bit_index++) begin
            lfsr_state = lfsr_next(lfsr_state);
            value = {value[14:0], lfsr_state[0]};
        end
    endtask

    // program rule: sum, then sum minus the and, then the or unless the sum is zero
    function automatic entry_t model_entry(input word_t x, input word_t y);
        entry_t entry;
        entry.x      = x;
        entry.y      = y;
        entry.sum    = x + y;
        entry.diff   = entry.sum - (x & y);
        entry.or_val = x | y;
        entry.has_or = (entry.sum != 16'd0);
        return entry;
    endfunction

    task automatic build_table();
        word_t x;
        word_t y;
        lfsr_state = 16'd89;
        for (int i = 0; i < entry_count; i++) begin
            if (i == 2) begin
                x = 16'h0000;
                y = 16'h0000;
            end else if (i == 5) begin
                // sum wraps to zero
                x = 16'hffff;
                y = 16'h0001;
            end else begin
                random_word(x);
                random_word(y);
            end
            entries[i] = model_entry(x, y);
        end
    endtask

    task automatic stop_with_failure(input string reason);
        $display("%s", reason);
        $display("*** FAILED ***");
        $fatal(1, "simulation stopped on the first error");
    endtask

    task automatic check_word(input string name, input word_t expected, input word_t actual);
        if (actual !== expected) begin
            stop_with_failure($sformatf("FAIL %s: expected %04h, actual %04h",
                                        name, expected, actual));
        end
    endtask

    // called on a falling edge, the current sample counts
    task automatic await_read(input string what);
        int   cycles;
        logic found;
        cycles = 0;
        found  = 1'b0;
        while (!found) begin
            if (write_strobe === 1'b1) begin
                stop_with_failure($sformatf("unexpected output %04h while waiting for %s",
                                            write_out, what));
            end
            if (read_strobe === 1'b1) begin
                found = 1'b1;
            end else if (cycles >= timeout_cycles) begin
                stop_with_failure($sformatf("no read_strobe for %s within %0d cycles",
                                            what, timeout_cycles));
            end else begin
                cycles++;
                @(negedge clock);
            end
        end
    endtask

    task automatic await_write(input string name, input word_t expected);
        int   cycles;
        logic found;
        cycles = 0;
        found  = 1'b0;
        while (!found) begin
            if (read_strobe === 1'b1) begin
                stop_with_failure($sformatf("read_strobe came while waiting for output %s",
                                            name));
            end
            if (write_strobe === 1'b1) begin
                check_word(name, expected, write_out);
                found = 1'b1;
            end else if (cycles >= timeout_cycles) begin
                stop_with_failure($sformatf("no write_strobe for %s within %0d cycles",
                                            name, timeout_cycles));
            end else begin
                cycles++;
                @(negedge clock);
            end
        end
    endtask

    initial begin
        entry_t entry;
        reset   = 1'b1;
        read_in = '0;
        build_table();
        read_in = entries[0].x;
        repeat (4) @(negedge clock);
        reset = 1'b0;
        for (int index = 0; index < entry_count; index++) begin
            entry = entries[index];
            await_read($sformatf("x of entry %0d", index));
            @(negedge clock);
            read_in = entry.y;
            await_read($sformatf("y of entry %0d", index));
            @(negedge clock);
            // next x is ready long before the next in
            if (index + 1 < entry_count) begin
                read_in = entries[index + 1].x;
            end else begin
                read_in = '0;
            end
            await_write($sformatf("entry %0d sum", index), entry.sum);
            @(negedge clock);
            await_write($sformatf("entry %0d difference", index), entry.diff);
            @(negedge clock);
            if (entry.has_or) begin
                await_write($sformatf("entry %0d or", index), entry.or_val);
                @(negedge clock);
            end
        end
        // no stray output, such as the flushed out r0, before the next pass reads
        await_read("the first read of the next pass");
        $display("*** PASSED ***");
        $finish;
    end

endmodule

// ==== memory_stage.sv ====
// ram uses the low address bits only; read_in must be steady through the read_strobe cycle
`timescale 1ns/100ps

module memory_stage import cpu_pkg::*; (
    input  logic       clock,
    input  logic       reset,
    em_bus.consumer    em,
    input  word_t      read_in,
    output logic       read_strobe,
    output word_t      write_out,
    output logic       write_strobe,
    output logic       wb_valid,
    output reg_index_t wb_rd,
    output word_t      wb_data
);

    word_t                     ram [ram_depth];
    logic [ram_addr_width-1:0] address;
    word_t                     load_data;

    assign address = em.alu_result[ram_addr_width-1:0];
    assign load_data = ram[address];

    // port word is taken at the end of this cycle
    assign read_strobe = em.valid && em.op == op_in;

    always_ff @(posedge clock) begin
        if (em.valid && em.op == op_st) begin
            ram[address] <= em.store_data;
        end
    end

    // output port, write_out holds between strobes
    always_ff @(posedge clock) begin
        if (reset) begin
            write_strobe <= 1'b0;
            write_out    <= '0;
        end else begin
            write_strobe <= em.valid && em.op == op_out;
            if (em.valid && em.op == op_out) begin
                write_out <= em.store_data;
            end
        end
    end

    // memory-to-writeback register
    always_ff @(posedge clock) begin
        if (reset) begin
            wb_valid <= 1'b0;
        end else begin
            wb_valid <= em.valid && em.reg_write;
        end
    end

    always_ff @(posedge clock) begin
        wb_rd <= em.rd;
        case (em.op)
            op_ld:   wb_data <= load_data;
            op_in:   wb_data <= read_in;
            default: wb_data <= em.alu_result;
        endcase
    end

endmodule

// ==== program.hex ====
// one instruction word per line from address 0, r format rs2 rs1 rd op, i format imm8 rd op
// loop: in, in, add, out, and, st, ld, sub, out, beq, or, out, jmp, then an out that is flushed
0018 // 0: in r1
0028 // 1: in r2
2131 // 2: add r3 = r1 + r2
3009 // 3: out r3
2143 // 4: and r4 = r1 & r2
4007 // 5: st r4 at address r0
0056 // 6: ld r5 from address r0
5362 // 7: sub r6 = r3 - r5
6009 // 8: out r6
032a // 9: beq r3, r0 to 12
2174 // 10: or r7 = r1 | r2
7009 // 11: out r7
f30b // 12: jmp to 0
0009 // 13: out r0
0000 // 14: nop
0000 // 15: nop

// ==== run.sh ====
#!/usr/bin/env bash
# builds the load_store testbench with Verilator and runs it from the project root

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -f list.f --top-module load_store_tb \
        -o sim_load_store; then
    echo "verilator build failed"
    exit 1
fi

output=$(./obj_dir/sim_load_store)
status=$?
echo "$output"

if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qF '*** PASSED ***' <<< "$output"; then
    exit 0
else
    exit 1
fi

// ==== stage_if.sv ====
// registered stage outputs only; valid qualifies every other field of a bus
`timescale 1ns/100ps

// decode to execute register
interface de_bus import cpu_pkg::*; ();
    logic       valid;
    word_t      pc;
    opcode_t    op;
    word_t      a;
    word_t      b;
    word_t      imm;
    reg_index_t rs1;
    reg_index_t rs2;
    reg_index_t rd;
    logic       reg_write;

    modport producer (output valid, pc, op, a, b, imm, rs1, rs2, rd, reg_write);
    modport consumer (input valid, pc, op, a, b, imm, rs1, rs2, rd, reg_write);
endinterface

// execute to memory register
interface em_bus import cpu_pkg::*; ();
    logic       valid;
    opcode_t    op;
    word_t      alu_result;
    word_t      store_data;
    reg_index_t rd;
    logic       reg_write;

    modport producer (output valid, op, alu_result, store_data, rd, reg_write);
    modport consumer (input valid, op, alu_result, store_data, rd, reg_write);
endinterface
